/* ray_pkg.sv */
// Integer coordinates only; image fixed at 8x8, so pixel_id is {py, px}.
package ray_pkg;

	localparam int coord_w = 16;
	localparam int img_w = 8;
	localparam int img_h = 8;
	localparam int num_pixels = 64;
	localparam int pixel_id_w = 6;
	localparam int pb_depth = 16;

	localparam logic [23:0] color_hit = 24'hFFFFFF;
	localparam logic [23:0] color_miss = 24'h000000;

	typedef struct packed {
		logic signed [coord_w-1:0] x;
		logic signed [coord_w-1:0] y;
		logic signed [coord_w-1:0] z;
	} vector_t;

	typedef struct packed {
		logic [pixel_id_w-1:0] pixel_id;
		vector_t origin;
		vector_t dir;
	} ray_t;

	// Axis-aligned box, bounds inclusive.
	typedef struct packed {
		logic signed [coord_w-1:0] xmin;
		logic signed [coord_w-1:0] xmax;
		logic signed [coord_w-1:0] ymin;
		logic signed [coord_w-1:0] ymax;
		logic signed [coord_w-1:0] zmin;
		logic signed [coord_w-1:0] zmax;
	} box_t;

	typedef struct packed {
		vector_t origin; // Grid corner, pixel 0.
		logic signed [coord_w-1:0] step;
	} camera_t;

	typedef struct packed {
		logic [pixel_id_w-1:0] pixel_id;
		logic [23:0] color;
	} pixel_entry_t;

	typedef enum logic [1:0] {
		idle,
		render,
		drain,
		done
	} frame_state_t;

endpackage

/* ray_scan_counter.sv */
// Issues at most one pixel per three cycles; stops after pixel 63 until the next scan_clear.
`timescale 1ns/1ns

module ray_scan_counter (
	input logic clk,
	input logic reset,
	input logic scan_en,
	input logic scan_clear,
	input logic pb_full,
	output logic v0,
	output logic v1,
	output logic v2,
	output logic issue,
	output logic last_issued,
	output logic [2:0] px,
	output logic [2:0] py
);
	import ray_pkg::*;

	logic [1:0] cnt;

	always_ff @(posedge clk) begin
		if (reset)
			cnt <= 2'd0;
		else
			cnt <= (cnt == 2'd2) ? 2'd0 : cnt + 2'd1;
	end

	assign v0 = (cnt == 2'd0);
	assign v1 = (cnt == 2'd1);
	assign v2 = (cnt == 2'd2);

	// Full FIFO holds the raster, phase keeps turning.
	assign issue = v2 && scan_en && !pb_full && !last_issued;

	always_ff @(posedge clk) begin
		if (reset || scan_clear) begin
			px <= 3'd0;
			py <= 3'd0;
			last_issued <= 1'b0;
		end else if (issue) begin
			if (px == 3'(img_w - 1)) begin
				px <= 3'd0;
				py <= py + 3'd1; // Wraps to 0 after the last row.
				if (py == 3'(img_h - 1))
					last_issued <= 1'b1;
			end else begin
				px <= px + 3'd1;
			end
		end
	end

endmodule

/* frame_control.sv */
// Start is taken only in idle or done; scene and cam must hold while busy.
`timescale 1ns/1ns

module frame_control (
	input logic clk,
	input logic reset,
	input logic start,
	input logic last_issued,
	input logic all_written,
	output ray_pkg::frame_state_t state,
	output logic scan_en,
	output logic scan_clear,
	output logic busy,
	output logic frame_done
);
	import ray_pkg::*;

	frame_state_t state_n;
	logic start_ok;

	assign start_ok = start && (state == idle || state == done);
	assign scan_clear = start_ok;

	always_comb begin
		state_n = state;
		case (state)
			idle: if (start_ok) state_n = render;
			render: if (last_issued) state_n = drain;
			drain: if (all_written) state_n = done;
			done: if (start_ok) state_n = render;
			default: state_n = idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			frame_done <= 1'b0;
		end else begin
			state <= state_n;
			frame_done <= (state == drain) && all_written; // One pulse on entry to done.
		end
	end

	assign scan_en = (state == render);
	assign busy = (state == render) || (state == drain);

endmodule

/* ray_gen.sv */
// Orthographic camera; coordinate products wrap at coord_w bits.
`timescale 1ns/1ns

module ray_gen (
	input logic clk,
	input logic reset,
	input logic issue,
	input logic [2:0] px,
	input logic [2:0] py,
	input ray_pkg::camera_t cam,
	output ray_pkg::ray_t ray,
	output logic ray_valid
);
	import ray_pkg::*;

	logic signed [coord_w-1:0] px_s;
	logic signed [coord_w-1:0] py_s;

	// Pixel indices are unsigned.
	assign px_s = coord_w'(px);
	assign py_s = coord_w'(py);

	always_ff @(posedge clk) begin
		if (reset)
			ray_valid <= 1'b0;
		else
			ray_valid <= issue;
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			ray.pixel_id <= pixel_id_w'(py * img_w + px);
			ray.origin.x <= cam.origin.x + px_s * cam.step;
			ray.origin.y <= cam.origin.y + py_s * cam.step;
			ray.origin.z <= cam.origin.z;
			ray.dir.x <= '0;
			ray.dir.y <= '0;
			ray.dir.z <= coord_w'(1); // Looking down +z.
		end
	end

endmodule

/* box_intersect.sv */
// Assumes dir = (0,0,1); zmin is not tested, only zmax against the ray origin.
`timescale 1ns/1ns

module box_intersect (
	input logic clk,
	input logic reset,
	input ray_pkg::ray_t ray,
	input logic ray_valid,
	input ray_pkg::box_t scene,
	output ray_pkg::pixel_entry_t ent,
	output logic ent_valid
);
	import ray_pkg::*;

	logic s1_valid;
	logic [pixel_id_w-1:0] s1_id;
	logic x_lo, x_hi, y_lo, y_hi;
	logic in_front;

	// Stage 1: slab compares.
	always_ff @(posedge clk) begin
		if (reset)
			s1_valid <= 1'b0;
		else
			s1_valid <= ray_valid;
	end

	always_ff @(posedge clk) begin
		if (ray_valid) begin
			s1_id <= ray.pixel_id;
			x_lo <= (ray.origin.x >= scene.xmin);
			x_hi <= (ray.origin.x <= scene.xmax);
			y_lo <= (ray.origin.y >= scene.ymin);
			y_hi <= (ray.origin.y <= scene.ymax);
			in_front <= (scene.zmax >= ray.origin.z);
		end
	end

	// Stage 2: combine and color.
	always_ff @(posedge clk) begin
		if (reset)
			ent_valid <= 1'b0;
		else
			ent_valid <= s1_valid;
	end

	always_ff @(posedge clk) begin
		if (s1_valid) begin
			ent.pixel_id <= s1_id;
			if (x_lo && x_hi && y_lo && y_hi && in_front)
				ent.color <= color_hit;
			else
				ent.color <= color_miss;
		end
	end

endmodule

/* pixel_fifo.sv */
// Full asserts with one slot still free; writes into a truly full FIFO are dropped.
`timescale 1ns/1ns

module pixel_fifo #(
	parameter int depth = ray_pkg::pb_depth
) (
	input logic clk,
	input logic reset,
	input ray_pkg::pixel_entry_t din,
	input logic we,
	input logic re,
	output ray_pkg::pixel_entry_t dout,
	output logic full,
	output logic empty
);
	import ray_pkg::*;

	pixel_entry_t mem [depth];
	logic [$clog2(depth)-1:0] wr_ptr;
	logic [$clog2(depth)-1:0] rd_ptr;
	logic [$clog2(depth+1)-1:0] count;
	logic do_wr, do_rd;

	assign do_wr = we && (count < depth);
	assign do_rd = re && !empty;

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= (wr_ptr == depth - 1) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == depth - 1) ? '0 : rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign dout = mem[rd_ptr]; // Head, fall-through.
	assign empty = (count == 0);
	assign full = (count >= depth - 1); // Leaves room for the entry in flight.

endmodule

/* frame_writer.sv */
// One write per cycle at most; all_written coincides with mem_we of write 64.
`timescale 1ns/1ns

module frame_writer (
	input logic clk,
	input logic reset,
	input ray_pkg::pixel_entry_t head,
	input logic empty,
	input logic mem_ready,
	input logic scan_clear,
	output logic re,
	output logic mem_we,
	output logic [ray_pkg::pixel_id_w-1:0] mem_addr,
	output logic [23:0] mem_data,
	output logic all_written
);
	import ray_pkg::*;

	logic [pixel_id_w:0] wr_count;

	assign re = !empty && mem_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			mem_we <= 1'b0;
			all_written <= 1'b0;
			wr_count <= '0;
		end else begin
			mem_we <= re;
			all_written <= re && (wr_count == num_pixels - 1);
			if (scan_clear)
				wr_count <= '0;
			else if (re)
				wr_count <= wr_count + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (re) begin
			mem_addr <= head.pixel_id;
			mem_data <= head.color;
		end
	end

endmodule

/* ray_demo_top.sv */
// One box per frame; scene and cam are sampled live and must hold until frame_done.
`timescale 1ns/1ns

module ray_demo_top (
	input logic clk,
	input logic reset,
	input logic start,
	input ray_pkg::box_t scene,
	input ray_pkg::camera_t cam,
	input logic mem_ready,
	output logic mem_we,
	output logic [ray_pkg::pixel_id_w-1:0] mem_addr,
	output logic [23:0] mem_data,
	output logic busy,
	output logic frame_done
);
	import ray_pkg::*;

	logic scan_en, scan_clear;
	logic issue, last_issued;
	logic [2:0] px, py;
	logic pb_full, pb_empty, pb_re;
	logic all_written;

	ray_t ray;
	logic ray_valid;
	pixel_entry_t ent, pb_head;
	logic ent_valid;

	// Phase taps left open; only v2 paces issue.
	ray_scan_counter u_scan (
		.clk,
		.reset,
		.scan_en,
		.scan_clear,
		.pb_full,
		.v0(),
		.v1(),
		.v2(),
		.issue,
		.last_issued,
		.px,
		.py
	);

	frame_control u_ctrl (
		.clk,
		.reset,
		.start,
		.last_issued,
		.all_written,
		.state(),
		.scan_en,
		.scan_clear,
		.busy,
		.frame_done
	);

	ray_gen u_gen (
		.clk,
		.reset,
		.issue,
		.px,
		.py,
		.cam,
		.ray,
		.ray_valid
	);

	box_intersect u_isect (
		.clk,
		.reset,
		.ray,
		.ray_valid,
		.scene,
		.ent,
		.ent_valid
	);

	pixel_fifo #(.depth(pb_depth)) u_fifo (
		.clk,
		.reset,
		.din(ent),
		.we(ent_valid),
		.re(pb_re),
		.dout(pb_head),
		.full(pb_full),
		.empty(pb_empty)
	);

	frame_writer u_writer (
		.clk,
		.reset,
		.head(pb_head),
		.empty(pb_empty),
		.mem_ready,
		.scan_clear,
		.re(pb_re),
		.mem_we,
		.mem_addr,
		.mem_data,
		.all_written
	);

endmodule

/* tb_clock.sv */
// Free-running 8 ns clock; reset held high for the first 4 rising edges.
`timescale 1ns/1ns

module tb_clock (
	output logic clk,
	output logic reset
);
	localparam int half_period = 4;
	localparam int reset_cycles = 4;

	initial begin
		clk = 1'b0;
		forever #half_period clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk); // Release away from the sampling edge.
		reset = 1'b0;
	end

endmodule

/* ray_demo_tb.sv */
// Reads ray_testdata.txt from the run directory; at most 16 tests, busy percentage below 100.
`timescale 1ns/1ns

module ray_demo_tb;
	import ray_pkg::*;

	localparam int max_tests = 16;

	logic clk, reset, start, mem_ready;
	box_t scene;
	camera_t cam;
	logic mem_we, busy, frame_done;
	logic [pixel_id_w-1:0] mem_addr;
	logic [23:0] mem_data;

	string names [max_tests];
	box_t boxes [max_tests];
	camera_t cams [max_tests];
	int busy_pct [max_tests];
	logic [7:0] rows [max_tests][img_h]; // Row per py, px 0 is the leftmost bit.
	int num_tests = 0;
	int limit_cycles = 0;
	bit tests_loaded = 1'b0;
	int cur_busy = 0;
	string cur_name = "reset";

	logic written [num_pixels];
	pixel_entry_t shadow [num_pixels]; // Writes in arrival order.
	int num_writes = 0;

	tb_clock u_clock (.clk, .reset);

	ray_demo_top DUT (
		.clk, .reset, .start, .scene, .cam, .mem_ready,
		.mem_we, .mem_addr, .mem_data, .busy, .frame_done
	);

	task automatic check_pixel(input string name, input pixel_entry_t exp, input pixel_entry_t act);
		if (act !== exp) begin
			$display("[FAIL] %s: expected pixel %0d color %06h, actual pixel %0d color %06h",
				name, exp.pixel_id, exp.color, act.pixel_id, act.color);
			$display("CHECKS FAILED");
			$fatal(1, "pixel mismatch");
		end
	endtask

	// Busy and frame_done as the given FSM state implies them.
	task automatic check_state(input string name, input frame_state_t exp_state,
			input logic busy_act, input logic done_act);
		logic [1:0] exp_flags;
		exp_flags = {exp_state == render || exp_state == drain, exp_state == done};
		if ({busy_act, done_act} !== exp_flags) begin
			$display("[FAIL] %s: expected busy/frame_done %b, actual %b",
				name, exp_flags, {busy_act, done_act});
			$display("CHECKS FAILED");
			$fatal(1, "state mismatch");
		end
	endtask

	task automatic stop_with(input string what);
		$display("%s", what);
		$display("CHECKS FAILED");
		$fatal(1, "run aborted");
	endtask

	task automatic load_tests();
		int fd;
		int n;
		string line;
		logic [8*16-1:0] name_bits;
		int b[6];
		int ox, oy, oz, step, pct;
		logic [7:0] r[img_h];
		fd = $fopen("ray_testdata.txt", "r");
		if (fd == 0)
			stop_with("Could not open ray_testdata.txt.");
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			if (num_tests == max_tests)
				stop_with("Too many tests in ray_testdata.txt.");
			n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %b %b %b %b %b %b %b %b",
				name_bits, b[0], b[1], b[2], b[3], b[4], b[5], ox, oy, oz, step, pct,
				r[0], r[1], r[2], r[3], r[4], r[5], r[6], r[7]);
			if (n != 20 || pct < 0 || pct > 99)
				stop_with("Malformed line in ray_testdata.txt.");
			names[num_tests] = string'(name_bits);
			boxes[num_tests] = {16'(b[0]), 16'(b[1]), 16'(b[2]), 16'(b[3]), 16'(b[4]), 16'(b[5])};
			cams[num_tests] = {16'(ox), 16'(oy), 16'(oz), 16'(step)};
			busy_pct[num_tests] = pct;
			for (int i = 0; i < img_h; i++)
				rows[num_tests][i] = r[i];
			// Three cycles per pixel, stretched by the busy ratio, doubled.
			limit_cycles += 32 + (num_pixels * 3 * 2 * 100) / (100 - pct);
			num_tests++;
		end
		$fclose(fd);
		if (num_tests == 0)
			stop_with("No tests found in ray_testdata.txt.");
	endtask

	task automatic run_test(input int t);
		int cycles;
		pixel_entry_t exp;
		cur_name = names[t];
		cur_busy = busy_pct[t];
		scene = boxes[t];
		cam = cams[t];
		for (int p = 0; p < num_pixels; p++)
			written[p] = 1'b0;
		num_writes = 0;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		cycles = 0;
		while (!frame_done) begin
			check_state(cur_name, render, busy, frame_done);
			start = (cycles == 20); // Stray start mid-frame.
			@(negedge clk);
			cycles++;
		end
		start = 1'b0;
		check_state(cur_name, done, busy, frame_done);
		@(negedge clk);
		if (frame_done)
			stop_with($sformatf("frame_done stayed high for more than one cycle in %s.", cur_name));
		// Raster order, so write p carries pixel p.
		for (int p = 0; p < num_pixels; p++) begin
			if (!written[p])
				stop_with($sformatf("Pixel %0d was never written in %s.", p, cur_name));
			exp.pixel_id = pixel_id_w'(p);
			exp.color = rows[t][p / img_w][img_w - 1 - (p % img_w)] ? color_hit : color_miss;
			check_pixel(cur_name, exp, shadow[p]);
		end
	endtask

	// Shadow frame of every memory write.
	always @(negedge clk) begin
		if (!reset && mem_we) begin
			if (written[mem_addr])
				stop_with($sformatf("Pixel %0d was written twice in %s.", mem_addr, cur_name));
			written[mem_addr] = 1'b1;
			shadow[num_writes] = {mem_addr, mem_data};
			num_writes++;
		end
	end

	initial begin
		void'($urandom(64));
		mem_ready = 1'b0;
		forever begin
			@(negedge clk);
			mem_ready = (int'($urandom % 100) >= cur_busy);
		end
	end

	initial begin
		wait (tests_loaded);
		repeat (limit_cycles) @(posedge clk);
		$display("Timeout: frames did not finish within %0d cycles.", limit_cycles);
		$display("CHECKS FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin
		start = 1'b0;
		scene = '0;
		cam = '0;
		load_tests();
		tests_loaded = 1'b1;
		@(negedge clk);
		while (reset)
			@(negedge clk);
		for (int t = 0; t < num_tests; t++)
			run_test(t);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

/* ray_testdata.txt */
# name xmin xmax ymin ymax zmin zmax org_x org_y org_z step busy% row0 .. row7
# each row is py 0..7 with px 0 leftmost; 1 = white hit, 0 = black miss
inside_box 2 5 1 3 0 10 0 0 0 1 0 00000000 00111100 00111100 00111100 00000000 00000000 00000000 00000000
edge_touch 10 12 30 34 0 5 10 20 5 2 30 00000000 00000000 00000000 00000000 00000000 11000000 11000000 11000000
off_grid 100 200 100 200 0 10 0 0 0 1 50 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
behind_camera -100 100 -100 100 -50 -1 0 0 0 1 20 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
busy_90 -4 3 -8 -5 0 3 -8 -8 3 2 90 00111100 00111100 00000000 00000000 00000000 00000000 00000000 00000000
neg_step -10 2 -7 -4 0 0 5 5 0 -3 40 00000000 00000000 00000000 01111100 01111100 00000000 00000000 00000000

/* filelist.f */
ray_pkg.sv
ray_scan_counter.sv
frame_control.sv
ray_gen.sv
box_intersect.sv
pixel_fifo.sv
frame_writer.sv
ray_demo_top.sv
tb_clock.sv
ray_demo_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module ray_demo_tb -f filelist.f -o ray_demo_sim

out=$(./obj_dir/ray_demo_sim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "ALL CHECKS PASSED"; then
	echo "Simulation passed."
else
	echo "Simulation failed."
	exit 1
fi
